// ==== hdl/lpif_flit_pack.sv ====
// Downstream flit pack: registers the LPIF downstream fields into the flit word
module lpif_flit_pack
  import lpif_pkg::*;
(
  input  logic       clk_wr,
  input  logic       reset,

  // Downstream LPIF channel
  input  lpif_flit_t dstrm,

  // Link readiness from sync
  input  link_ctl_t  ctl,

  // Word toward the lane map
  output flit_word_u tx_word
);

  ////////////////////////////////////////////////////////////////////////////
  // Field view register

  // Nothing leaves before the delayed tx online
  always_ff @(posedge clk_wr) begin
    if (reset || !ctl.tx_online_dly) begin
      tx_word.flit <= '0;
    end else begin
      // Field by field into the union
      tx_word.flit.state     <= dstrm.state;
      tx_word.flit.protid    <= dstrm.protid;
      tx_word.flit.data      <= dstrm.data;
      tx_word.flit.dvalid    <= dstrm.dvalid;
      tx_word.flit.crc       <= dstrm.crc;
      tx_word.flit.crc_valid <= dstrm.crc_valid;
      tx_word.flit.valid     <= dstrm.valid;
    end
  end

endmodule

// ==== hdl/lpif_flit_unpack.sv ====
// Upstream flit unpack: registers the received flit word into the LPIF upstream fields
module lpif_flit_unpack
  import lpif_pkg::*;
(
  input  logic       clk_wr,
  input  logic       reset,

  // Word rebuilt by the lane map
  input  flit_word_u rx_word,

  // Link readiness from sync
  input  link_ctl_t  ctl,

  // Upstream LPIF channel
  output lpif_flit_t ustrm
);

  ////////////////////////////////////////////////////////////////////////////
  // Upstream register

  // Held at zero until the delayed rx online
  always_ff @(posedge clk_wr) begin
    if (reset || !ctl.rx_online_dly) begin
      ustrm <= '0;
    end else begin
      ustrm.state     <= rx_word.flit.state;
      ustrm.protid    <= rx_word.flit.protid;
      ustrm.data      <= rx_word.flit.data;
      ustrm.dvalid    <= rx_word.flit.dvalid;
      ustrm.crc       <= rx_word.flit.crc;
      ustrm.crc_valid <= rx_word.flit.crc_valid;
      ustrm.valid     <= rx_word.flit.valid;
    end
  end

endmodule

// ==== hdl/lpif_lane_map.sv ====
// Lane map: flit word onto two PHY lanes with strobe/marker, and word recovery from rx lanes
module lpif_lane_map
  import lpif_pkg::*;
(
  input  logic              clk_wr,
  input  logic              reset,

  // Transmit side
  input  flit_word_u        tx_word,
  input  link_ctl_t         ctl,
  output logic [LANE_W-1:0] tx_phy0,
  output logic [LANE_W-1:0] tx_phy1,

  // Receive side
  input  logic [LANE_W-1:0] rx_phy0,
  input  logic [LANE_W-1:0] rx_phy1,
  output flit_word_u        rx_word
);

  logic [LANE_W-1:0] tx_lane0_d;
  logic [LANE_W-1:0] tx_lane1_d;

  // Payload arrives zero extended, so spare bits stay 0
  function automatic logic [LANE_W-1:0] build_lane(input logic [LANE_W-1:0] payload,
                                                   input link_ctl_t         c);
    logic [LANE_W-1:0] lane;
    lane                    = payload;
    lane[STB_BIT]           = c.stb;
    lane[MRK_LSB +: MRK_W]  = c.mrk;
    return lane;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transmit lanes

  // Lane 0 low part, lane 1 high part
  always_comb begin
    tx_lane0_d = build_lane(LANE_W'(tx_word.lanes.lo), ctl);
    tx_lane1_d = build_lane(LANE_W'(tx_word.lanes.hi), ctl);
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx_lane0_d;
      tx_phy1 <= tx_lane1_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive lanes

  // Only data bits come back; strobe and marker dropped here
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_word.lanes <= '0;
    end else begin
      rx_word.lanes.lo <= rx_phy0[LANE0_BITS-1:0];
      rx_word.lanes.hi <= rx_phy1[LANE1_BITS-1:0];
    end
  end

endmodule

// ==== hdl/lpif_link_sync.sv ====
// Link sync: tx/rx online delay counters, periodic strobe and word marker
module lpif_link_sync
  import lpif_pkg::*;
(
  input  logic               clk_wr,
  input  logic               reset,
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,
  output link_ctl_t          ctl
);

  logic [DELAY_W-1:0] tx_cnt;
  logic [DELAY_W-1:0] rx_cnt;
  logic [DELAY_W-1:0] tx_cnt_nxt;
  logic [DELAY_W-1:0] rx_cnt_nxt;
  logic               tx_dly;
  logic               rx_dly;
  logic [DELAY_W-1:0] stb_cnt;
  logic [DELAY_W:0]   stb_cnt_inc;

  // Count up to the limit, then hold
  function automatic logic [DELAY_W-1:0] sat_next(input logic [DELAY_W-1:0] cnt,
                                                  input logic [DELAY_W-1:0] limit);
    if (cnt >= limit) begin
      return cnt;
    end
    return cnt + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Online delays

  assign tx_cnt_nxt = sat_next(tx_cnt, delay_y_value);
  assign rx_cnt_nxt = sat_next(rx_cnt, delay_x_value);

  // Delay restarts as soon as the raw online drops
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_cnt <= '0;
      tx_dly <= 1'b0;
    end else begin
      tx_cnt <= tx_cnt_nxt;
      tx_dly <= (tx_cnt_nxt >= delay_y_value);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      rx_cnt <= '0;
      rx_dly <= 1'b0;
    end else begin
      rx_cnt <= rx_cnt_nxt;
      rx_dly <= (rx_cnt_nxt >= delay_x_value);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe period

  // Extra bit so the increment cannot wrap before the compare
  assign stb_cnt_inc = {1'b0, stb_cnt} + 1'b1;

  // Modulo delay_z count; zero period keeps it parked at 0
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_dly) begin
      stb_cnt <= '0;
    end else if (stb_cnt_inc >= {1'b0, delay_z_value}) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt_inc[DELAY_W-1:0];
    end
  end

  // Sideband out, all decoded from registered state
  always_comb begin
    ctl.tx_online_dly = tx_dly;
    ctl.rx_online_dly = rx_dly;
    ctl.stb           = tx_dly && (stb_cnt == '0);
    // Marker held at one, every word is complete
    ctl.mrk           = tx_dly ? MRK_W'(1) : '0;
  end

endmodule

// ==== hdl/lpif_master_top.sv ====
// LPIF x2 master top: link sync, flit pack, lane map, flit unpack and debug status
module lpif_master_top
  import lpif_pkg::*;
(
  input  logic               clk_wr,
  input  logic               reset,

  // Link control
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  // PHY lanes
  output logic [LANE_W-1:0]  tx_phy0,
  output logic [LANE_W-1:0]  tx_phy1,
  input  logic [LANE_W-1:0]  rx_phy0,
  input  logic [LANE_W-1:0]  rx_phy1,

  // LPIF channels
  input  lpif_flit_t         dstrm,
  output lpif_flit_t         ustrm,

  // Debug status
  output logic [31:0]        tx_downstream_debug_status,
  output logic [31:0]        rx_upstream_debug_status
);

  link_ctl_t  ctl;
  flit_word_u tx_word;
  flit_word_u rx_word;

  ////////////////////////////////////////////////////////////////////////////
  // Sync and debug

  lpif_link_sync i_link_sync (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .ctl           (ctl)
  );

  // Bit 19 tx online, bit 18 rx online
  assign tx_downstream_debug_status = {12'h0, ctl.tx_online_dly, ctl.rx_online_dly, 18'h0};
  assign rx_upstream_debug_status   = {12'h0, ctl.tx_online_dly, ctl.rx_online_dly, 18'h0};

  ////////////////////////////////////////////////////////////////////////////
  // Data path

  lpif_flit_pack i_flit_pack (
    .clk_wr  (clk_wr),
    .reset   (reset),
    .dstrm   (dstrm),
    .ctl     (ctl),
    .tx_word (tx_word)
  );

  lpif_lane_map i_lane_map (
    .clk_wr  (clk_wr),
    .reset   (reset),
    .tx_word (tx_word),
    .ctl     (ctl),
    .tx_phy0 (tx_phy0),
    .tx_phy1 (tx_phy1),
    .rx_phy0 (rx_phy0),
    .rx_phy1 (rx_phy1),
    .rx_word (rx_word)
  );

  lpif_flit_unpack i_flit_unpack (
    .clk_wr  (clk_wr),
    .reset   (reset),
    .rx_word (rx_word),
    .ctl     (ctl),
    .ustrm   (ustrm)
  );

endmodule

// ==== hdl/lpif_pkg.sv ====
// LPIF link package: flit field widths, lane layout, flit struct, lane word union
package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Flit field widths

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 128;
  localparam int CRC_W    = 4;

  // Whole flit, all fields packed back to back
  localparam int FLIT_W   = 141;

  ////////////////////////////////////////////////////////////////////////////
  // PHY lane layout

  localparam int LANE_W     = 80;
  // Lane 0 carries the low part of the flit word
  localparam int LANE0_BITS = 70;
  // Lane 1 takes whatever is left over
  localparam int LANE1_BITS = FLIT_W - LANE0_BITS;
  // Top bit of each lane is the strobe
  localparam int STB_BIT    = 79;
  // Marker pair sits right under the strobe
  localparam int MRK_LSB    = 77;
  localparam int MRK_W      = 2;

  // Online delay and strobe period values
  localparam int DELAY_W    = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Flit and lane views

  // One LPIF channel beat, downstream or upstream
  typedef struct packed {
    logic [STATE_W-1:0]  state;
    logic [PROTID_W-1:0] protid;
    logic [DATA_W-1:0]   data;
    logic                dvalid;
    logic [CRC_W-1:0]    crc;
    logic                crc_valid;
    logic                valid;
  } lpif_flit_t;

  // Same word seen as the two lane payloads
  typedef struct packed {
    logic [LANE1_BITS-1:0] hi;
    logic [LANE0_BITS-1:0] lo;
  } lane_split_t;

  // Flit word, field view for pack/unpack, lane view for the lane map
  typedef union packed {
    lpif_flit_t  flit;
    lane_split_t lanes;
  } flit_word_u;

  // Link readiness and lane sideband bits
  typedef struct packed {
    logic             tx_online_dly;
    logic             rx_online_dly;
    logic             stb;
    logic [MRK_W-1:0] mrk;
  } link_ctl_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lpif_master -f sources.f

output=$(./obj_dir/Vtb_lpif_master 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi

// ==== sources.f ====
hdl/lpif_pkg.sv
hdl/lpif_link_sync.sv
hdl/lpif_flit_pack.sv
hdl/lpif_lane_map.sv
hdl/lpif_flit_unpack.sv
hdl/lpif_master_top.sv
verification/tb_lpif_master.sv

// ==== verification/tb_lpif_master.sv ====
// LPIF master testbench with clock, reset, LFSR stimulus, lane loopback, model and compare tasks
module tb_lpif_master
  import lpif_pkg::*;
();

  logic               clk_wr;
  logic               reset;
  logic               tx_online;
  logic               rx_online;
  logic [DELAY_W-1:0] delay_x_value;
  logic [DELAY_W-1:0] delay_y_value;
  logic [DELAY_W-1:0] delay_z_value;
  logic [LANE_W-1:0]  tx_phy0;
  logic [LANE_W-1:0]  tx_phy1;
  logic [LANE_W-1:0]  rx_phy0;
  logic [LANE_W-1:0]  rx_phy1;
  lpif_flit_t         dstrm;
  lpif_flit_t         ustrm;
  logic [31:0]        tx_downstream_debug_status;
  logic [31:0]        rx_upstream_debug_status;
  logic [15:0]        lfsr;
  logic               chk_en;

  // Model state
  int                 m_tx_run;
  int                 m_rx_run;
  int                 m_phase;
  logic               m_tx_dly;
  logic               m_rx_dly;
  logic               m_stb;
  flit_word_u         m_tx_word;
  flit_word_u         m_lane_word;
  flit_word_u         m_rx_word;
  logic [LANE_W-1:0]  m_lane0;
  logic [LANE_W-1:0]  m_lane1;
  lpif_flit_t         m_ustrm;
  logic [31:0]        m_dbg;

  lpif_master_top i_dut (
    .clk_wr                     (clk_wr),
    .reset                      (reset),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .dstrm                      (dstrm),
    .ustrm                      (ustrm),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  // Lanes wired straight back from tx into rx
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  always #5 clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per flit bit
  task automatic fill_flit(output lpif_flit_t f);
    logic [FLIT_W-1:0] bits;
    bits = '0;
    for (int i = 0; i < FLIT_W; i++) begin
      lfsr    = lfsr_next(lfsr);
      bits[i] = lfsr[0];
    end
    f = bits;
  endtask

  // Inputs change 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
    fill_flit(dstrm);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  // Payload low with the marker pair at 78:77 and the strobe on top
  function automatic logic [LANE_W-1:0] expect_lane(input logic [LANE_W-1:0] payload,
                                                    input logic stb, input logic on);
    logic [LANE_W-1:0] lane;
    lane               = payload;
    lane[STB_BIT]      = stb;
    lane[MRK_LSB +: 2] = on ? 2'b01 : 2'b00;
    return lane;
  endfunction

  // Strobe once per delay_z cycles from the first online cycle
  always_comb begin
    if (!m_tx_dly) begin
      m_stb = 1'b0;
    end else if (delay_z_value == '0) begin
      m_stb = 1'b1;
    end else begin
      m_stb = (m_phase % int'(delay_z_value)) == 0;
    end
  end

  assign m_dbg = {12'h0, m_tx_dly, m_rx_dly, 18'h0};

  always @(posedge clk_wr) begin
    if (reset) begin
      m_tx_run    <= 0;
      m_rx_run    <= 0;
      m_phase     <= 0;
      m_tx_dly    <= 1'b0;
      m_rx_dly    <= 1'b0;
      m_tx_word   <= '0;
      m_lane_word <= '0;
      m_rx_word   <= '0;
      m_lane0     <= '0;
      m_lane1     <= '0;
      m_ustrm     <= '0;
    end else begin
      // Edges seen with online high
      m_tx_run <= tx_online ? m_tx_run + 1 : 0;
      m_rx_run <= rx_online ? m_rx_run + 1 : 0;
      m_tx_dly <= tx_online && (m_tx_run + 1 >= 32'(delay_y_value));
      m_rx_dly <= rx_online && (m_rx_run + 1 >= 32'(delay_x_value));
      m_phase  <= m_tx_dly ? m_phase + 1 : 0;
      // Flit history gated by the online delays
      m_tx_word.flit <= m_tx_dly ? dstrm : '0;
      m_lane_word    <= m_tx_word;
      m_lane0        <= expect_lane(LANE_W'(m_tx_word.lanes.lo), m_stb, m_tx_dly);
      m_lane1        <= expect_lane(LANE_W'(m_tx_word.lanes.hi), m_stb, m_tx_dly);
      m_rx_word      <= m_lane_word;
      m_ustrm        <= m_rx_dly ? m_rx_word.flit : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_flit(input string name, input lpif_flit_t exp, input lpif_flit_t act);
    if (act !== exp) begin
      $display("ERROR: time %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_lanes(input logic [LANE_W-1:0] exp0, input logic [LANE_W-1:0] exp1,
                             input logic [LANE_W-1:0] act0, input logic [LANE_W-1:0] act1);
    if (act0 !== exp0) begin
      $display("ERROR: time %0t tx_phy0 expected %h actual %h", $time, exp0, act0);
      abort_run();
    end
    if (act1 !== exp1) begin
      $display("ERROR: time %0t tx_phy1 expected %h actual %h", $time, exp1, act1);
      abort_run();
    end
  endtask

  task automatic check_debug(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR: time %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Outputs settled mid cycle
  always @(negedge clk_wr) begin
    if (chk_en) begin
      check_flit("ustrm", m_ustrm, ustrm);
      check_lanes(m_lane0, m_lane1, tx_phy0, tx_phy1);
      check_debug("tx_downstream_debug_status", m_dbg, tx_downstream_debug_status);
      check_debug("rx_upstream_debug_status", m_dbg, rx_upstream_debug_status);
    end
  end

  // Edges until a debug bit reads one
  task automatic wait_debug_rise(input logic [4:0] bit_idx, input int exp_cycles,
                                 input string name);
    int n;
    n = 0;
    do begin
      @(posedge clk_wr);
      n++;
      @(negedge clk_wr);
      if (n > 50) begin
        $display("Timeout: %s never rose on the debug status", name);
        abort_run();
      end
    end while (tx_downstream_debug_status[bit_idx] !== 1'b1);
    if (n != exp_cycles) begin
      $display("ERROR: time %0t %s rise delay expected %0d actual %0d",
               $time, name, exp_cycles, n);
      abort_run();
    end
  endtask

  task automatic wait_ustrm_idle();
    int n;
    n = 0;
    while (ustrm !== '0) begin
      @(negedge clk_wr);
      n++;
      if (n > 10) begin
        $display("Timeout: ustrm did not return to zero after tx_online dropped");
        abort_run();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    clk_wr        = 1'b0;
    reset         = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = 16'd7;
    delay_y_value = 16'd5;
    delay_z_value = 16'd3;
    dstrm         = '0;
    lfsr          = 16'd41630;
    chk_en        = 1'b0;
    repeat (3) @(posedge clk_wr);
    #1;
    reset  = 1'b0;
    chk_en = 1'b1;
    // Random flits must not leak out while offline
    repeat (4) next_cycle();
    tx_online = 1'b1;
    wait_debug_rise(5'd19, 5, "tx_online_dly");
    next_cycle();
    rx_online = 1'b1;
    wait_debug_rise(5'd18, 7, "rx_online_dly");
    // Full loopback traffic
    repeat (300) next_cycle();
    tx_online = 1'b0;
    wait_ustrm_idle();
    repeat (4) next_cycle();
    // Strobe stays high with a zero period
    delay_z_value = '0;
    tx_online     = 1'b1;
    wait_debug_rise(5'd19, 5, "tx_online_dly");
    repeat (20) next_cycle();
    $display("No errors");
    $finish;
  end

endmodule
